// ==== common/alpha_pkg.sv ====
/*
  Shared constants for the Alpha-subset front end.
  Only integer operate, memory, branch, JSR and the PAL halt/whami
  functions are decoded. Everything else is treated as illegal.
  Encodings of the select codes must match the downstream datapath.
*/

package alpha_pkg;

  //////////////////////////////////////////////////
  // major opcodes, inst[31:26]
  localparam logic [5:0] PAL_INST   = 6'h00;
  localparam logic [5:0] LDA_INST   = 6'h08;
  localparam logic [5:0] INTA_GRP   = 6'h10;  // add, sub, compares
  localparam logic [5:0] INTL_GRP   = 6'h11;  // logicals
  localparam logic [5:0] INTS_GRP   = 6'h12;  // shifts
  localparam logic [5:0] INTM_GRP   = 6'h13;  // multiply
  localparam logic [5:0] ITFP_GRP   = 6'h14;
  localparam logic [5:0] FLTV_GRP   = 6'h15;
  localparam logic [5:0] FLTI_GRP   = 6'h16;
  localparam logic [5:0] FLTL_GRP   = 6'h17;
  localparam logic [5:0] MISC_GRP   = 6'h18;
  localparam logic [5:0] JSR_GRP    = 6'h1a;  // jmp, jsr, ret, jsr_co
  localparam logic [5:0] FTPI_GRP   = 6'h1c;
  localparam logic [5:0] LDQ_INST   = 6'h29;
  localparam logic [5:0] LDQ_L_INST = 6'h2b;
  localparam logic [5:0] STQ_INST   = 6'h2d;
  localparam logic [5:0] STQ_C_INST = 6'h2f;
  localparam logic [5:0] BR_INST    = 6'h30;
  localparam logic [5:0] FBEQ_INST  = 6'h31;
  localparam logic [5:0] FBLT_INST  = 6'h32;
  localparam logic [5:0] FBLE_INST  = 6'h33;
  localparam logic [5:0] BSR_INST   = 6'h34;
  localparam logic [5:0] FBNE_INST  = 6'h35;
  localparam logic [5:0] FBGE_INST  = 6'h36;
  localparam logic [5:0] FBGT_INST  = 6'h37;

  // operate function field, inst[11:5]
  localparam logic [6:0] ADDQ_INST   = 7'h20;
  localparam logic [6:0] SUBQ_INST   = 7'h29;
  localparam logic [6:0] CMPEQ_INST  = 7'h2d;
  localparam logic [6:0] CMPLT_INST  = 7'h4d;
  localparam logic [6:0] CMPLE_INST  = 7'h6d;
  localparam logic [6:0] CMPULT_INST = 7'h1d;
  localparam logic [6:0] CMPULE_INST = 7'h3d;
  localparam logic [6:0] AND_INST    = 7'h00;
  localparam logic [6:0] BIC_INST    = 7'h08;
  localparam logic [6:0] BIS_INST    = 7'h20;  // same code as addq, other group
  localparam logic [6:0] ORNOT_INST  = 7'h28;
  localparam logic [6:0] XOR_INST    = 7'h40;
  localparam logic [6:0] EQV_INST    = 7'h48;
  localparam logic [6:0] SRL_INST    = 7'h34;
  localparam logic [6:0] SLL_INST    = 7'h39;
  localparam logic [6:0] SRA_INST    = 7'h3c;
  localparam logic [6:0] MULQ_INST   = 7'h20;

  // pal functions, inst[25:0]
  localparam logic [25:0] PAL_HALT  = 26'h0000;
  localparam logic [25:0] PAL_WHAMI = 26'h003c;

  //////////////////////////////////////////////////
  // alu function codes
  localparam logic [4:0] ALU_ADDQ   = 5'h00;
  localparam logic [4:0] ALU_SUBQ   = 5'h01;
  localparam logic [4:0] ALU_AND    = 5'h02;
  localparam logic [4:0] ALU_BIC    = 5'h03;
  localparam logic [4:0] ALU_BIS    = 5'h04;
  localparam logic [4:0] ALU_ORNOT  = 5'h05;
  localparam logic [4:0] ALU_XOR    = 5'h06;
  localparam logic [4:0] ALU_EQV    = 5'h07;
  localparam logic [4:0] ALU_SRL    = 5'h08;
  localparam logic [4:0] ALU_SLL    = 5'h09;
  localparam logic [4:0] ALU_SRA    = 5'h0a;
  localparam logic [4:0] ALU_MULQ   = 5'h0b;
  localparam logic [4:0] ALU_CMPULT = 5'h0c;
  localparam logic [4:0] ALU_CMPEQ  = 5'h0d;
  localparam logic [4:0] ALU_CMPULE = 5'h0e;
  localparam logic [4:0] ALU_CMPLT  = 5'h0f;
  localparam logic [4:0] ALU_CMPLE  = 5'h10;

  // operand muxes
  localparam logic [1:0] ALU_OPA_IS_REGA     = 2'h0;
  localparam logic [1:0] ALU_OPA_IS_MEM_DISP = 2'h1;
  localparam logic [1:0] ALU_OPA_IS_NPC      = 2'h2;
  localparam logic [1:0] ALU_OPA_IS_NOT3     = 2'h3;  // mask for jump align
  localparam logic [1:0] ALU_OPB_IS_REGB     = 2'h0;
  localparam logic [1:0] ALU_OPB_IS_ALU_IMM  = 2'h1;
  localparam logic [1:0] ALU_OPB_IS_BR_DISP  = 2'h2;

  // writeback destination
  localparam logic [1:0] DEST_IS_REGC = 2'h0;
  localparam logic [1:0] DEST_IS_REGA = 2'h1;
  localparam logic [1:0] DEST_NONE    = 2'h2;
  localparam logic [4:0] ZERO_REG     = 5'd31;

  // one instruction word, three views
  // rb shares bits with literal[7:3], read it through mem_fmt
  typedef union packed {
    struct packed {
      logic [5:0] opcode;
      logic [4:0] ra;
      logic [7:0] literal;  // rb plus three sbz bits when lit_flag low
      logic       lit_flag;
      logic [6:0] func;
      logic [4:0] rc;
    } op_fmt;
    struct packed {
      logic [5:0]  opcode;
      logic [4:0]  ra;
      logic [4:0]  rb;
      logic [15:0] disp16;
    } mem_fmt;
    struct packed {
      logic [5:0]  opcode;
      logic [4:0]  ra;
      logic [20:0] disp21;
    } br_fmt;
  } alpha_inst_u;

endpackage

// ==== common/inst_if.sv ====
/*
  Valid/ready link carrying one instruction word and its pc.
  Payload must hold steady while valid is high and ready is low.
*/
`timescale 1ns/1ps

interface inst_if;
  logic        valid;  // word present
  logic        ready;  // sink can take it this cycle
  logic [31:0] inst;
  logic [63:0] pc;     // address of inst

  modport src (
    output valid,
    output inst,
    output pc,
    input  ready
  );

  modport snk (
    input  valid,
    input  inst,
    input  pc,
    output ready
  );
endinterface

// ==== fetch/fetch_unit.sv ====
/*
  Fetch slot. One registered entry, refilled in the cycle it drains.
  pc starts at RESET_PC and steps by 4 per accepted word.
  No redirect path, words are assumed sequential.
*/
`timescale 1ns/1ps

module fetch_unit #(
  parameter logic [63:0] RESET_PC = 64'h0
) (
  input  logic        clock,
  input  logic        rst_n,
  input  logic        in_valid,
  output logic        in_ready,
  input  logic [31:0] in_inst,
  inst_if.src         f2q
);

  logic        slot_valid;
  logic [31:0] slot_inst;
  logic [63:0] slot_pc;
  logic [63:0] pc_cnt;   // pc of the next accepted word
  logic        accept;

  // take a new word if slot empty or leaving now
  assign in_ready = ~slot_valid | f2q.ready;
  assign accept   = in_valid & in_ready;

  assign f2q.valid = slot_valid;
  assign f2q.inst  = slot_inst;
  assign f2q.pc    = slot_pc;

  //////////////////////////////////////////////////
  // control state
  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      slot_valid <= 1'b0;
      pc_cnt     <= RESET_PC;
    end
    else
    begin
      if (accept)
      begin
        slot_valid <= 1'b1;
        pc_cnt     <= pc_cnt + 64'd4;
      end
      else if (f2q.ready)
        slot_valid <= 1'b0;  // drained, nothing behind it
    end
  end

  // payload
  always_ff @(posedge clock)
  begin
    if (accept)
    begin
      slot_inst <= in_inst;
      slot_pc   <= pc_cnt;
    end
  end

endmodule

// ==== design/if_id_fifo.sv ====
/*
  IF/ID queue. DEPTH must be a power of two and at least 2.
  Head is read straight from storage, valid one cycle after the write.
  When full, a write is taken only alongside a read in the same cycle.
*/
`timescale 1ns/1ps

module if_id_fifo #(
  parameter int DEPTH = 4
) (
  input  logic clock,
  input  logic rst_n,
  inst_if.snk  wr,
  inst_if.src  rd
);

  localparam int AW = $clog2(DEPTH);
  localparam logic [AW:0] FULL_CNT = AW'(0) + (AW+1)'(DEPTH);

  logic [31:0]   inst_mem [DEPTH];
  logic [63:0]   pc_mem   [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          do_wr;
  logic          do_rd;

  assign rd.valid = (count != '0);
  assign rd.inst  = inst_mem[rd_ptr];
  assign rd.pc    = pc_mem[rd_ptr];

  // full blocks writes unless the head leaves this cycle
  assign wr.ready = (count != FULL_CNT) | rd.ready;

  assign do_wr = wr.valid & wr.ready;
  assign do_rd = rd.valid & rd.ready;

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is 2**AW
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_wr && !do_rd)
        count <= count + 1'b1;
      else if (do_rd && !do_wr)
        count <= count - 1'b1;
    end
  end

  // storage
  always_ff @(posedge clock)
  begin
    if (do_wr)
    begin
      inst_mem[wr_ptr] <= wr.inst;
      pc_mem[wr_ptr]   <= wr.pc;
    end
  end

endmodule

// ==== decode/decoder.sv ====
/*
  Combinational decode of one Alpha-subset word. No valid input.
  Illegal words give noop controls, a zero immediate and illegal high.
  FP, MISC, FTPI and unassigned opcodes all count as illegal.
*/
`timescale 1ns/1ps

module decoder
  import alpha_pkg::*;
(
  input  alpha_inst_u inst,
  output logic [1:0]  opa_select,
  output logic [1:0]  opb_select,
  output logic [1:0]  dest_select,
  output logic [4:0]  alu_func,
  output logic        rd_mem,
  output logic        wr_mem,
  output logic        ldl_mem,
  output logic        stc_mem,
  output logic        cond_branch,
  output logic        uncond_branch,
  output logic        halt,
  output logic        cpuid,
  output logic        illegal,
  output logic [63:0] imm
);

  logic [5:0] opc;

  assign opc = inst.op_fmt.opcode;  // same bits in every view

  always_comb
  begin
    // noop
    opa_select    = 2'h0;
    opb_select    = 2'h0;
    dest_select   = DEST_NONE;
    alu_func      = 5'h0;
    rd_mem        = 1'b0;
    wr_mem        = 1'b0;
    ldl_mem       = 1'b0;
    stc_mem       = 1'b0;
    cond_branch   = 1'b0;
    uncond_branch = 1'b0;
    halt          = 1'b0;
    cpuid         = 1'b0;
    illegal       = 1'b0;
    imm           = 64'h0;

    case (opc[5:3])
      3'h0:  // pal group, only call_pal itself
      begin
        if (opc != PAL_INST)
          illegal = 1'b1;
        else if (inst[25:0] == PAL_HALT)
          halt = 1'b1;
        else if (inst[25:0] == PAL_WHAMI)
        begin
          cpuid       = 1'b1;
          dest_select = DEST_IS_REGA;  // cpu id goes to ra
        end
        else
          illegal = 1'b1;
      end

      3'h2:  // integer operate
      begin
        opa_select  = ALU_OPA_IS_REGA;
        opb_select  = inst.op_fmt.lit_flag ? ALU_OPB_IS_ALU_IMM : ALU_OPB_IS_REGB;
        dest_select = DEST_IS_REGC;
        if (inst.op_fmt.lit_flag)
          imm = {56'h0, inst.op_fmt.literal};  // zero extended
        case (opc)
          INTA_GRP:
            case (inst.op_fmt.func)
              ADDQ_INST:   alu_func = ALU_ADDQ;
              SUBQ_INST:   alu_func = ALU_SUBQ;
              CMPEQ_INST:  alu_func = ALU_CMPEQ;
              CMPLT_INST:  alu_func = ALU_CMPLT;
              CMPLE_INST:  alu_func = ALU_CMPLE;
              CMPULT_INST: alu_func = ALU_CMPULT;
              CMPULE_INST: alu_func = ALU_CMPULE;
              default:     illegal  = 1'b1;
            endcase
          INTL_GRP:
            case (inst.op_fmt.func)
              AND_INST:   alu_func = ALU_AND;
              BIC_INST:   alu_func = ALU_BIC;
              BIS_INST:   alu_func = ALU_BIS;
              ORNOT_INST: alu_func = ALU_ORNOT;
              XOR_INST:   alu_func = ALU_XOR;
              EQV_INST:   alu_func = ALU_EQV;
              default:    illegal  = 1'b1;
            endcase
          INTS_GRP:
            case (inst.op_fmt.func)
              SRL_INST: alu_func = ALU_SRL;
              SLL_INST: alu_func = ALU_SLL;
              SRA_INST: alu_func = ALU_SRA;
              default:  illegal  = 1'b1;
            endcase
          INTM_GRP:
            if (inst.op_fmt.func == MULQ_INST)
              alu_func = ALU_MULQ;
            else
              illegal = 1'b1;
          ITFP_GRP, FLTV_GRP, FLTI_GRP, FLTL_GRP: illegal = 1'b1;  // no fp
          default: illegal = 1'b1;
        endcase
      end

      3'h3:  // misc and jumps
        case (opc)
          JSR_GRP:
          begin
            // all four jump flavours behave alike here
            opa_select    = ALU_OPA_IS_NOT3;
            opb_select    = ALU_OPB_IS_REGB;
            alu_func      = ALU_AND;  // clear low two bits of rb
            dest_select   = DEST_IS_REGA;
            uncond_branch = 1'b1;
          end
          MISC_GRP, FTPI_GRP: illegal = 1'b1;  // unimplemented
          default:            illegal = 1'b1;
        endcase

      3'h1, 3'h4, 3'h5:  // memory format
      begin
        opa_select  = ALU_OPA_IS_MEM_DISP;
        opb_select  = ALU_OPB_IS_REGB;
        alu_func    = ALU_ADDQ;  // rb + disp
        dest_select = DEST_IS_REGA;
        imm         = {{48{inst.mem_fmt.disp16[15]}}, inst.mem_fmt.disp16};
        case (opc)
          LDA_INST:   dest_select = DEST_IS_REGA;  // address only
          LDQ_INST:   rd_mem = 1'b1;
          LDQ_L_INST:
          begin
            rd_mem  = 1'b1;
            ldl_mem = 1'b1;
          end
          STQ_INST:
          begin
            wr_mem      = 1'b1;
            dest_select = DEST_NONE;
          end
          STQ_C_INST:
          begin
            wr_mem  = 1'b1;
            stc_mem = 1'b1;  // ra gets success flag
          end
          default: illegal = 1'b1;
        endcase
      end

      default:  // 3'h6 and 3'h7, branch format
      begin
        opa_select = ALU_OPA_IS_NPC;
        opb_select = ALU_OPB_IS_BR_DISP;
        alu_func   = ALU_ADDQ;
        imm        = {{41{inst.br_fmt.disp21[20]}}, inst.br_fmt.disp21, 2'b00};
        case (opc)
          FBEQ_INST, FBLT_INST, FBLE_INST,
          FBNE_INST, FBGE_INST, FBGT_INST: illegal = 1'b1;
          BR_INST, BSR_INST:
          begin
            dest_select   = DEST_IS_REGA;  // return address
            uncond_branch = 1'b1;
          end
          default: cond_branch = 1'b1;  // integer conditionals
        endcase
      end
    endcase

    // back to noop, keep only the flag
    if (illegal)
    begin
      opa_select    = 2'h0;
      opb_select    = 2'h0;
      dest_select   = DEST_NONE;
      alu_func      = 5'h0;
      rd_mem        = 1'b0;
      wr_mem        = 1'b0;
      ldl_mem       = 1'b0;
      stc_mem       = 1'b0;
      cond_branch   = 1'b0;
      uncond_branch = 1'b0;
      imm           = 64'h0;
    end
  end

endmodule

// ==== decode/id_stage.sv ====
/*
  Decode stage. Decodes the queue head into one registered output slot.
  A halt stops intake while it sits in the slot. Once it leaves,
  halted stays high until reset and out_valid stays low.
*/
`timescale 1ns/1ps

module id_stage
  import alpha_pkg::*;
(
  input  logic        clock,
  input  logic        rst_n,
  inst_if.snk         q2d,
  output logic        out_valid,
  input  logic        out_ready,
  output logic [63:0] out_pc,
  output logic [1:0]  out_opa_select,
  output logic [1:0]  out_opb_select,
  output logic [4:0]  out_alu_func,
  output logic [4:0]  out_dest_reg_idx,
  output logic [63:0] out_imm,
  output logic        out_rd_mem,
  output logic        out_wr_mem,
  output logic        out_ldl_mem,
  output logic        out_stc_mem,
  output logic        out_cond_branch,
  output logic        out_uncond_branch,
  output logic        out_halt,
  output logic        out_cpuid,
  output logic        out_illegal,
  output logic        halted
);

  alpha_inst_u head;
  logic [1:0]  opa_select, opb_select, dest_select;
  logic [4:0]  alu_func;
  logic [4:0]  dest_idx;
  logic        rd_mem, wr_mem, ldl_mem, stc_mem;
  logic        cond_branch, uncond_branch, halt, cpuid, illegal;
  logic [63:0] imm;
  logic        take;

  assign head = q2d.inst;

  // decoder outputs match local names
  decoder u_decoder (
    .inst (head),
    .*
  );

  // writeback index
  always_comb
  begin
    case (dest_select)
      DEST_IS_REGC: dest_idx = head.op_fmt.rc;
      DEST_IS_REGA: dest_idx = head.op_fmt.ra;
      default:      dest_idx = ZERO_REG;  // dest_none
    endcase
  end

  // refill while draining, but never behind a halt
  assign q2d.ready = ~halted & (~out_valid | (out_ready & ~out_halt));
  assign take      = q2d.valid & q2d.ready;

  //////////////////////////////////////////////////
  // slot control and halt latch
  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_valid <= 1'b0;
      halted    <= 1'b0;
    end
    else
    begin
      if (take)
        out_valid <= 1'b1;
      else if (out_ready)
        out_valid <= 1'b0;
      if (out_valid && out_ready && out_halt)
        halted <= 1'b1;  // sticky
    end
  end

  // decoded payload
  always_ff @(posedge clock)
  begin
    if (take)
    begin
      out_pc            <= q2d.pc;
      out_opa_select    <= opa_select;
      out_opb_select    <= opb_select;
      out_alu_func      <= alu_func;
      out_dest_reg_idx  <= dest_idx;
      out_imm           <= imm;
      out_rd_mem        <= rd_mem;
      out_wr_mem        <= wr_mem;
      out_ldl_mem       <= ldl_mem;
      out_stc_mem       <= stc_mem;
      out_cond_branch   <= cond_branch;
      out_uncond_branch <= uncond_branch;
      out_halt          <= halt;
      out_cpuid         <= cpuid;
      out_illegal       <= illegal;
    end
  end

endmodule

// ==== design/front_end_top.sv ====
/*
  Front end top. Fetch slot, IF/ID queue and decode slot in series.
  At least 3 cycles from input to output, up to DEPTH+2 words in flight.
  DEPTH must be a power of two and at least 2.
*/
`timescale 1ns/1ps

module front_end_top #(
  parameter int          DEPTH    = 4,
  parameter logic [63:0] RESET_PC = 64'h0
) (
  input  logic        clock,
  input  logic        rst_n,
  input  logic        in_valid,
  output logic        in_ready,
  input  logic [31:0] in_inst,
  output logic        out_valid,
  input  logic        out_ready,
  output logic [63:0] out_pc,
  output logic [1:0]  out_opa_select,
  output logic [1:0]  out_opb_select,
  output logic [4:0]  out_alu_func,
  output logic [4:0]  out_dest_reg_idx,
  output logic [63:0] out_imm,
  output logic        out_rd_mem,
  output logic        out_wr_mem,
  output logic        out_ldl_mem,
  output logic        out_stc_mem,
  output logic        out_cond_branch,
  output logic        out_uncond_branch,
  output logic        out_halt,
  output logic        out_cpuid,
  output logic        out_illegal,
  output logic        halted
);

  inst_if f2q ();  // fetch to queue
  inst_if q2d ();  // queue to decode

  // port names line up with the top level
  fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (.*);

  if_id_fifo #(.DEPTH(DEPTH)) u_queue (
    .clock (clock),
    .rst_n (rst_n),
    .wr    (f2q),
    .rd    (q2d)
  );

  id_stage u_decode (.*);

endmodule

// ==== verif/clock_gen.sv ====
/*
  Free-running testbench clock, 20 ns period.
  Starts low at time zero.
*/
`timescale 1ns/1ps

module clock_gen (
  output logic clock
);

  initial clock = 1'b0;

  always #10 clock = ~clock;  // half period

endmodule

// ==== verif/front_end_properties.sv ====
/*
  Handshake and halt properties for the front end top.
  Bound into front_end_top, watches only its top level ports.
*/
`timescale 1ns/1ps

module front_end_properties (
  input logic        clock,
  input logic        rst_n,
  input logic        in_valid,
  input logic        in_ready,
  input logic        out_valid,
  input logic        out_ready,
  input logic [63:0] out_pc,
  input logic        halted
);

  logic seen_input;  // first input transfer done

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
      seen_input <= 1'b0;
    else if (in_valid && in_ready)
      seen_input <= 1'b1;
  end

  //////////////////////////////////////////////////
  // stalled output holds still
  assert property (@(posedge clock) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_pc))
    else $error("output slot changed while stalled");

  assert property (@(posedge clock) disable iff (!rst_n) halted |-> !out_valid)
    else $error("out_valid high after halt");

  // nothing comes out before anything went in
  assert property (@(posedge clock) disable iff (!rst_n)
    !seen_input |-> !out_valid && !halted)
    else $error("output activity before the first input word");

endmodule

bind front_end_top front_end_properties u_props (
  .clock     (clock),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_pc    (out_pc),
  .halted    (halted)
);

// ==== verif/tb_front_end.sv ====
/*
  Testbench for front_end_top. Directed words, then seeded random words,
  then a halt. out_ready and input gaps are random throughout.
  Expected fields come from decode_ref, pc from the word's index.
*/
`timescale 1ns/1ps

module tb_front_end
  import alpha_pkg::*;
;

  localparam int          DEPTH      = 4;
  localparam logic [63:0] RESET_PC   = 64'h1000;
  localparam int          WAIT_LIMIT = 200;  // cycles per wait
  localparam int          N_RANDOM   = 300;

  // op group and func pairs, every legal operate instruction
  localparam logic [12:0] OP_LIST [17] = '{
    {INTA_GRP, ADDQ_INST},  {INTA_GRP, SUBQ_INST},   {INTA_GRP, CMPEQ_INST},
    {INTA_GRP, CMPLT_INST}, {INTA_GRP, CMPLE_INST},  {INTA_GRP, CMPULT_INST},
    {INTA_GRP, CMPULE_INST}, {INTL_GRP, AND_INST},   {INTL_GRP, BIC_INST},
    {INTL_GRP, BIS_INST},   {INTL_GRP, ORNOT_INST},  {INTL_GRP, XOR_INST},
    {INTL_GRP, EQV_INST},   {INTS_GRP, SRL_INST},    {INTS_GRP, SLL_INST},
    {INTS_GRP, SRA_INST},   {INTM_GRP, MULQ_INST}
  };

  // memory, branch, jump, pal and a few illegal words
  localparam logic [31:0] DIRECT_LIST [18] = '{
    {LDA_INST, 5'd1, 5'd2, 16'h8000},   {LDQ_INST, 5'd3, 5'd4, 16'h0010},
    {LDQ_L_INST, 5'd5, 5'd6, 16'hfff8}, {STQ_INST, 5'd7, 5'd8, 16'h7fff},
    {STQ_C_INST, 5'd9, 5'd10, 16'h0100},
    {BR_INST, 5'd11, 21'h1fffff},       {BSR_INST, 5'd26, 21'h000400},
    {6'h38, 5'd12, 21'h100000},         {6'h3d, 5'd13, 21'h0000ff},
    {6'h3f, 5'd14, 21'h0abcde},
    {JSR_GRP, 5'd26, 5'd27, 16'h4000},  32'h0000_003c,
    {ITFP_GRP, 26'h123456},             {FBNE_INST, 26'h1},
    {MISC_GRP, 26'h0},                  {6'h01, 26'h0},
    {PAL_INST, 26'h1234},               {INTA_GRP, 5'd1, 8'd2, 1'b0, 7'h7f, 5'd3}
  };

  typedef struct packed {
    logic [31:0] word;
    logic [63:0] pc;
    logic [1:0]  opa;
    logic [1:0]  opb;
    logic [4:0]  alu;
    logic [4:0]  dest;
    logic [63:0] imm;
    logic        rd_mem, wr_mem, ldl_mem, stc_mem;
    logic        cond_br, uncond_br, halt, cpuid, illegal;
  } exp_t;

  logic        clock, rst_n;
  logic        in_valid, in_ready;
  logic [31:0] in_inst;
  logic        out_valid, out_ready;
  logic [63:0] out_pc, out_imm;
  logic [1:0]  out_opa_select, out_opb_select;
  logic [4:0]  out_alu_func, out_dest_reg_idx;
  logic        out_rd_mem, out_wr_mem, out_ldl_mem, out_stc_mem;
  logic        out_cond_branch, out_uncond_branch, out_halt, out_cpuid, out_illegal;
  logic        halted;

  exp_t exp_q[$];   // words in flight, oldest first
  exp_t head;
  int   seed = 7;
  int   word_idx = 0;
  int   checked = 0;
  int   mismatch_cnt = 0;
  int   other_cnt = 0;
  bit   aborted = 1'b0;  // a wait timed out, skip the rest

  clock_gen u_clock (.clock(clock));

  front_end_top #(.DEPTH(DEPTH), .RESET_PC(RESET_PC)) u_front_end_top (.*);

  //////////////////////////////////////////////////
  // reference decode
  function automatic exp_t decode_ref(input logic [31:0] w, input logic [63:0] pc);
    exp_t       e;
    logic [5:0] opc;
    logic [1:0] dsel;
    logic       op_hit;
    e      = '0;
    e.word = w;
    e.pc   = pc;
    opc    = w[31:26];
    dsel   = DEST_NONE;
    op_hit = 1'b1;
    case ({opc, w[11:5]})
      {INTA_GRP, ADDQ_INST}:   e.alu = ALU_ADDQ;
      {INTA_GRP, SUBQ_INST}:   e.alu = ALU_SUBQ;
      {INTA_GRP, CMPEQ_INST}:  e.alu = ALU_CMPEQ;
      {INTA_GRP, CMPLT_INST}:  e.alu = ALU_CMPLT;
      {INTA_GRP, CMPLE_INST}:  e.alu = ALU_CMPLE;
      {INTA_GRP, CMPULT_INST}: e.alu = ALU_CMPULT;
      {INTA_GRP, CMPULE_INST}: e.alu = ALU_CMPULE;
      {INTL_GRP, AND_INST}:    e.alu = ALU_AND;
      {INTL_GRP, BIC_INST}:    e.alu = ALU_BIC;
      {INTL_GRP, BIS_INST}:    e.alu = ALU_BIS;
      {INTL_GRP, ORNOT_INST}:  e.alu = ALU_ORNOT;
      {INTL_GRP, XOR_INST}:    e.alu = ALU_XOR;
      {INTL_GRP, EQV_INST}:    e.alu = ALU_EQV;
      {INTS_GRP, SRL_INST}:    e.alu = ALU_SRL;
      {INTS_GRP, SLL_INST}:    e.alu = ALU_SLL;
      {INTS_GRP, SRA_INST}:    e.alu = ALU_SRA;
      {INTM_GRP, MULQ_INST}:   e.alu = ALU_MULQ;
      default:                 op_hit = 1'b0;
    endcase
    if (opc == PAL_INST)
    begin
      if (w[25:0] == PAL_HALT)
        e.halt = 1'b1;
      else if (w[25:0] == PAL_WHAMI)
      begin
        e.cpuid = 1'b1;
        dsel    = DEST_IS_REGA;
      end
      else
        e.illegal = 1'b1;
    end
    else if (op_hit)
    begin
      e.opa = ALU_OPA_IS_REGA;
      e.opb = w[12] ? ALU_OPB_IS_ALU_IMM : ALU_OPB_IS_REGB;
      e.imm = w[12] ? {56'h0, w[20:13]} : 64'h0;  // literal only
      dsel  = DEST_IS_REGC;
    end
    else if (opc == JSR_GRP)
    begin
      e.opa       = ALU_OPA_IS_NOT3;
      e.opb       = ALU_OPB_IS_REGB;
      e.alu       = ALU_AND;
      e.uncond_br = 1'b1;
      dsel        = DEST_IS_REGA;
    end
    else if (opc inside {LDA_INST, LDQ_INST, LDQ_L_INST, STQ_INST, STQ_C_INST})
    begin
      e.opa     = ALU_OPA_IS_MEM_DISP;
      e.opb     = ALU_OPB_IS_REGB;
      e.alu     = ALU_ADDQ;
      e.imm     = {{48{w[15]}}, w[15:0]};
      e.rd_mem  = (opc == LDQ_INST) || (opc == LDQ_L_INST);
      e.ldl_mem = (opc == LDQ_L_INST);
      e.wr_mem  = (opc == STQ_INST) || (opc == STQ_C_INST);
      e.stc_mem = (opc == STQ_C_INST);
      dsel      = (opc == STQ_INST) ? DEST_NONE : DEST_IS_REGA;
    end
    else if (opc[5:4] == 2'b11 && !(opc inside {FBEQ_INST, FBLT_INST, FBLE_INST,
                                                 FBNE_INST, FBGE_INST, FBGT_INST}))
    begin
      e.opa       = ALU_OPA_IS_NPC;
      e.opb       = ALU_OPB_IS_BR_DISP;
      e.alu       = ALU_ADDQ;
      e.imm       = {{41{w[20]}}, w[20:0], 2'b00};  // word displacement
      e.uncond_br = (opc == BR_INST) || (opc == BSR_INST);
      e.cond_br   = !e.uncond_br;
      dsel        = e.uncond_br ? DEST_IS_REGA : DEST_NONE;
    end
    else
      e.illegal = 1'b1;
    case (dsel)
      DEST_IS_REGC: e.dest = w[4:0];
      DEST_IS_REGA: e.dest = w[25:21];
      default:      e.dest = ZERO_REG;
    endcase
    return e;
  endfunction

  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp)
    else
    begin
      mismatch_cnt++;
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus, all on the falling edge
  task automatic advance_cycle();
    @(negedge clock);
    out_ready = (($random(seed) & 3) != 0);  // ready 3 cycles in 4
  endtask

  task automatic send_word(input logic [31:0] w);
    int waited;
    bit done;
    waited = 0;
    done   = 1'b0;
    if (aborted)
      return;
    advance_cycle();
    if (($random(seed) & 3) == 0)
    begin
      in_valid = 1'b0;  // idle gap
      advance_cycle();
    end
    in_valid = 1'b1;
    in_inst  = w;
    while (!done && waited < WAIT_LIMIT)
    begin
      @(posedge clock);
      if (in_ready)
      begin
        done = 1'b1;
        exp_q.push_back(decode_ref(w, RESET_PC + 64'(word_idx) * 64'd4));
        word_idx++;
      end
      else
      begin
        waited++;
        advance_cycle();
      end
    end
    if (!done)
    begin
      other_cnt++;
      aborted = 1'b1;
      $display("ERROR: in_ready stayed low for %0d cycles", WAIT_LIMIT);
    end
  endtask

  // halt, then keep pushing until the pipe backs up
  task automatic run_halt();
    int waited;
    int post_cnt;
    bit done;
    waited   = 0;
    post_cnt = 0;
    done     = 1'b0;
    send_word(32'h0000_0000);
    while (!aborted && !done && waited < WAIT_LIMIT * 4)
    begin
      advance_cycle();
      in_valid = 1'b1;
      in_inst  = {INTA_GRP, 5'd1, 8'd2, 1'b0, ADDQ_INST, 5'(post_cnt)};
      @(posedge clock);
      if (in_ready)
        post_cnt++;
      else if (halted)
        done = 1'b1;
      waited++;
    end
    advance_cycle();
    in_valid = 1'b0;
    if (aborted)
      return;
    assert (done)
    else
    begin
      other_cnt++;
      $display("ERROR: halted and a stalled input never seen together");
    end
    check_field("words accepted after halt", 64'(post_cnt), 64'(DEPTH + 1));
    assert (exp_q.size() == 0)
    else
    begin
      other_cnt++;
      $display("ERROR: %0d words never came out before the halt", exp_q.size());
    end
    repeat (20) advance_cycle();  // pipe must stay quiet
    check_field("in_ready", 64'(in_ready), 64'h0);
  endtask

  //////////////////////////////////////////////////
  // scoreboard
  always @(posedge clock)
  begin
    if (rst_n && out_valid && out_ready)
    begin
      assert (exp_q.size() != 0)
      else
      begin
        other_cnt++;
        $display("ERROR: output word at pc %h with nothing outstanding", out_pc);
      end
      if (exp_q.size() != 0)
      begin
        head = exp_q.pop_front();
        checked++;
        check_field("out_pc", out_pc, head.pc);
        check_field("out_opa_select", 64'(out_opa_select), 64'(head.opa));
        check_field("out_opb_select", 64'(out_opb_select), 64'(head.opb));
        check_field("out_alu_func", 64'(out_alu_func), 64'(head.alu));
        check_field("out_dest_reg_idx", 64'(out_dest_reg_idx), 64'(head.dest));
        check_field("out_imm", out_imm, head.imm);
        check_field("out_rd_mem", 64'(out_rd_mem), 64'(head.rd_mem));
        check_field("out_wr_mem", 64'(out_wr_mem), 64'(head.wr_mem));
        check_field("out_ldl_mem", 64'(out_ldl_mem), 64'(head.ldl_mem));
        check_field("out_stc_mem", 64'(out_stc_mem), 64'(head.stc_mem));
        check_field("out_cond_branch", 64'(out_cond_branch), 64'(head.cond_br));
        check_field("out_uncond_branch", 64'(out_uncond_branch), 64'(head.uncond_br));
        check_field("out_halt", 64'(out_halt), 64'(head.halt));
        check_field("out_cpuid", 64'(out_cpuid), 64'(head.cpuid));
        check_field("out_illegal", 64'(out_illegal), 64'(head.illegal));
      end
    end
  end

  initial
  begin
    logic [31:0] w;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_inst   = 32'h0;
    out_ready = 1'b0;
    repeat (16) @(negedge clock);
    rst_n = 1'b1;
    advance_cycle();
    check_field("out_valid", 64'(out_valid), 64'h0);
    check_field("halted", 64'(halted), 64'h0);
    check_field("in_ready", 64'(in_ready), 64'h1);

    // every operate function, literal form on odd entries
    for (int i = 0; i < 17; i++)
      send_word({OP_LIST[i][12:7], 5'(i), 8'(8 * i + 5), 1'(i % 2),
                 OP_LIST[i][6:0], 5'(i + 3)});
    foreach (DIRECT_LIST[i])
      send_word(DIRECT_LIST[i]);

    for (int i = 0; i < N_RANDOM; i++)
    begin
      w = $random(seed);
      if (w == 32'h0)
        w = 32'h1;  // zero is halt, keep it for the end
      send_word(w);
    end

    run_halt();

    $display("summary: %0d words checked, %0d mismatches, %0d other errors",
             checked, mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== sim.f ====
common/alpha_pkg.sv
common/inst_if.sv
fetch/fetch_unit.sv
design/if_id_fifo.sv
decode/decoder.sv
decode/id_stage.sv
design/front_end_top.sv
verif/clock_gen.sv
verif/front_end_properties.sv
verif/tb_front_end.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the front end testbench with Verilator.
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_front_end -o sim_front_end
./obj_dir/sim_front_end | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
